// File: Makefile
VERILATOR  ?= verilator
TOP        ?= bpred_tb
RTL_TOP    ?= bpred_top
FLIST      ?= bpred.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= -Wall
PASS_MSG   ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# pass only if the testbench printed the pass line.
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)

// File: bench/bpred_tb.sv
// default parameters only; the model expects a lookup to see state from before a same-cycle update.
`default_nettype none
`timescale 1ns/1ps

module bpred_tb
    import bpred_pkg::*;
();

    localparam int BTB_ENTRIES = 32;
    localparam int GHR_BITS    = 5;
    localparam int BTB_IDX     = $clog2(BTB_ENTRIES);
    localparam int N_HIST      = 40;
    localparam int N_STREAM    = 40;
    // directed parts stay under 100 cycles, random parts cost about one cycle per item.
    localparam int TIMEOUT_CYCLES = 6 * (100 + 3 * N_HIST + 2 * N_STREAM);
    localparam logic [XLEN-1:0] POOL_BASE = 32'h0000_4000;
    localparam upd_req_t NO_UPD = '0;

    logic      clk;
    logic      arst_n_i;
    logic      pred_req_valid_i;
    pred_req_t pred_req_i;
    logic      upd_valid_i;
    upd_req_t  upd_i;
    logic      hist_clear_i;
    logic      pred_valid_o;
    pred_rsp_t pred_o;

    // ------------------------------
    // reference model state
    // ------------------------------
    logic                m_valid  [BTB_ENTRIES];
    logic [XLEN-1:0]     m_tag    [BTB_ENTRIES];
    logic [XLEN-1:0]     m_target [BTB_ENTRIES];
    br_kind_e            m_kind   [BTB_ENTRIES];
    logic [1:0]          m_pht    [1 << GHR_BITS];
    logic [GHR_BITS-1:0] m_ghr;

    integer seed;
    int     errors;
    int     checks;
    int     cycles;

    bpred_top i_dut (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .pred_req_valid_i (pred_req_valid_i),
        .pred_req_i       (pred_req_i),
        .upd_valid_i      (upd_valid_i),
        .upd_i            (upd_i),
        .hist_clear_i     (hist_clear_i),
        .pred_valid_o     (pred_valid_o),
        .pred_o           (pred_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    task automatic tick();
        @(posedge clk);
        #1; // drive point, outputs settled.
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    function automatic logic [XLEN-1:0] rand_pc();
        logic [XLEN-1:0] v;
        v = $random(seed);
        return {v[XLEN-1:2], 2'b00};
    endfunction

    function automatic logic rand_bit();
        logic [XLEN-1:0] v;
        v = $random(seed);
        return v[0];
    endfunction

    function automatic int rand_pool_idx();
        int v;
        v = $random(seed);
        return v & 7;
    endfunction

    // eight pcs on distinct target-buffer entries.
    function automatic logic [XLEN-1:0] pool_pc(input int k);
        return POOL_BASE + 32'(4 * k);
    endfunction

    function automatic upd_req_t make_upd(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] tgt,
                                          input br_kind_e kind, input logic taken);
        upd_req_t u;
        u.pc     = pc;
        u.target = tgt;
        u.kind   = kind;
        u.taken  = taken;
        return u;
    endfunction

    // ------------------------------
    // model rules
    // ------------------------------
    function automatic pred_rsp_t expect_pred(input logic [XLEN-1:0] pc);
        logic [BTB_IDX-1:0]  bi;
        logic [GHR_BITS-1:0] pi;
        pred_rsp_t           r;
        bi = pc[BTB_IDX+1:2];
        pi = pc[GHR_BITS+1:2] ^ m_ghr;
        r.hit   = m_valid[bi] && (m_tag[bi] == pc);
        r.taken = r.hit && ((m_kind[bi] == BR_JUMP) || ((m_kind[bi] == BR_COND) && m_pht[pi][1]));
        r.next_pc = r.taken ? m_target[bi] : pc + 32'd4;
        return r;
    endfunction

    function automatic void model_update(input upd_req_t u, input logic valid, input logic clear);
        logic [BTB_IDX-1:0]  bi;
        logic [GHR_BITS-1:0] pi;
        bi = u.pc[BTB_IDX+1:2];
        pi = u.pc[GHR_BITS+1:2] ^ m_ghr; // old history.
        if (valid && u.kind != BR_NONE) begin
            m_valid[bi]  = 1'b1;
            m_tag[bi]    = u.pc;
            m_target[bi] = u.target;
            m_kind[bi]   = u.kind;
        end
        if (valid && u.kind == BR_COND) begin
            if (u.taken && m_pht[pi] != 2'd3) m_pht[pi] = m_pht[pi] + 2'd1;
            if (!u.taken && m_pht[pi] != 2'd0) m_pht[pi] = m_pht[pi] - 2'd1;
        end
        if (clear) begin
            m_ghr = '0;
        end else if (valid && u.kind == BR_COND) begin
            m_ghr = {m_ghr[GHR_BITS-2:0], u.taken};
        end
    endfunction

    // one cycle of stimulus; the response is due exactly one cycle later.
    task automatic step(input logic do_req, input logic [XLEN-1:0] pc, input logic do_upd,
                        input upd_req_t u, input logic clear);
        pred_rsp_t exp;
        exp = expect_pred(pc);
        pred_req_valid_i = do_req;
        pred_req_i.pc    = pc;
        upd_valid_i      = do_upd;
        upd_i            = u;
        hist_clear_i     = clear;
        model_update(u, do_upd, clear);
        tick();
        pred_req_valid_i = 1'b0;
        upd_valid_i      = 1'b0;
        hist_clear_i     = 1'b0;
        if (!do_req) begin
            check_value("pred_valid_o", 32'(pred_valid_o), 32'd0);
        end else if (pred_valid_o !== 1'b1) begin
            errors++;
            $display("error at %0t: no response one cycle after the lookup at pc %h", $time, pc);
        end else begin
            check_value("pred_o.hit", 32'(pred_o.hit), 32'(exp.hit));
            check_value("pred_o.taken", 32'(pred_o.taken), 32'(exp.taken));
            check_value("pred_o.next_pc", pred_o.next_pc, exp.next_pc);
        end
    endtask

    task automatic lookup(input logic [XLEN-1:0] pc);
        step(1'b1, pc, 1'b0, NO_UPD, 1'b0);
    endtask

    task automatic train(input upd_req_t u, input logic clear);
        step(1'b0, '0, 1'b1, u, clear);
    endtask

    task automatic clear_history();
        step(1'b0, '0, 1'b0, NO_UPD, 1'b1);
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic test_after_reset();
        logic [XLEN-1:0] pc;
        step(1'b0, '0, 1'b0, NO_UPD, 1'b0);
        for (int i = 0; i < 6; i++) begin
            pc = rand_pc();
            lookup(pc);
            check_value("pred_o.hit", 32'(pred_o.hit), 32'd0);
            check_value("pred_o.next_pc", pred_o.next_pc, pc + 32'd4);
            step(1'b0, '0, 1'b0, NO_UPD, 1'b0);
        end
    endtask

    task automatic test_jump_entry();
        logic [XLEN-1:0] pa;
        logic [XLEN-1:0] pb;
        pa = 32'h0000_1040;
        pb = pa + 32'(BTB_ENTRIES * 4); // same index, other tag.
        train(make_upd(pa, 32'h0000_2468, BR_JUMP, 1'b1), 1'b0);
        lookup(pa);
        check_value("pred_o.taken", 32'(pred_o.taken), 32'd1);
        check_value("pred_o.next_pc", pred_o.next_pc, 32'h0000_2468);
        lookup(pb);
        check_value("pred_o.hit", 32'(pred_o.hit), 32'd0);
        train(make_upd(pb, 32'h0000_3570, BR_JUMP, 1'b1), 1'b0);
        lookup(pa);
        check_value("pred_o.hit", 32'(pred_o.hit), 32'd0);
        lookup(pb);
        check_value("pred_o.next_pc", pred_o.next_pc, 32'h0000_3570);
    endtask

    task automatic train_at_zero(input logic [XLEN-1:0] pc, input logic taken, input int n);
        for (int i = 0; i < n; i++) begin
            clear_history();
            train(make_upd(pc, 32'h0000_0a00, BR_COND, taken), 1'b1);
        end
    endtask

    task automatic test_counter_training();
        logic [XLEN-1:0] pc;
        pc = 32'h0000_0200;
        clear_history();
        // install pc while history is nonzero, leaving its zero-history counter untouched.
        train(make_upd(32'h0000_0304, 32'h0000_0900, BR_COND, 1'b1), 1'b0);
        train(make_upd(pc, 32'h0000_0a00, BR_COND, 1'b0), 1'b0);
        clear_history();
        lookup(pc);
        check_value("pred_o.taken", 32'(pred_o.taken), 32'd0);
        train_at_zero(pc, 1'b1, 1);
        lookup(pc);
        check_value("pred_o.taken", 32'(pred_o.taken), 32'd1);
        // one step past the top, so a wrapping counter would end up low.
        train_at_zero(pc, 1'b1, 3);
        train_at_zero(pc, 1'b0, 1);
        lookup(pc);
        check_value("pred_o.taken", 32'(pred_o.taken), 32'd1);
        train_at_zero(pc, 1'b0, 2);
        lookup(pc);
        check_value("pred_o.taken", 32'(pred_o.taken), 32'd0);
        check_value("pred_o.next_pc", pred_o.next_pc, pc + 32'd4);
    endtask

    task automatic test_history();
        int k;
        for (int i = 0; i < N_HIST; i++) begin
            k = rand_pool_idx();
            train(make_upd(pool_pc(k), 32'h0001_0000 + 32'(k << 6), BR_COND, rand_bit()), 1'b0);
            lookup(pool_pc(rand_pool_idx()));
        end
        for (int i = 0; i < N_HIST; i++) begin
            lookup(rand_bit() ? pool_pc(rand_pool_idx()) : rand_pc());
        end
    endtask

    task automatic test_same_cycle();
        logic [XLEN-1:0] pc;
        pc = 32'h0000_6100;
        lookup(pc);
        step(1'b1, pc, 1'b1, make_upd(pc, 32'h0000_7000, BR_JUMP, 1'b1), 1'b0);
        check_value("pred_o.hit", 32'(pred_o.hit), 32'd0);
        lookup(pc);
        check_value("pred_o.next_pc", pred_o.next_pc, 32'h0000_7000);
    endtask

    task automatic test_stream();
        upd_req_t u;
        for (int i = 0; i < N_STREAM; i++) begin
            u = make_upd(pool_pc(rand_pool_idx()), rand_pc(), BR_NONE, rand_bit());
            step(1'b1, pool_pc(rand_pool_idx()), i[0], u, 1'b0);
        end
        for (int k = 0; k < 8; k++) begin
            lookup(pool_pc(k));
        end
        step(1'b0, '0, 1'b0, NO_UPD, 1'b0);
    endtask

    initial begin
        seed   = 32'h5ea4;
        errors = 0;
        checks = 0;
        cycles = 0;
        clk              = 1'b0;
        arst_n_i         = 1'b0;
        pred_req_valid_i = 1'b0;
        pred_req_i       = '0;
        upd_valid_i      = 1'b0;
        upd_i            = '0;
        hist_clear_i     = 1'b0;
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            m_valid[i]  = 1'b0;
            m_tag[i]    = '0;
            m_target[i] = '0;
            m_kind[i]   = BR_NONE;
        end
        for (int i = 0; i < (1 << GHR_BITS); i++) m_pht[i] = CTR_INIT;
        m_ghr = '0;
        repeat (2) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        test_after_reset();
        test_jump_entry();
        test_counter_training();
        test_history();
        test_same_cycle();
        test_stream();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bpred.f
common/bpred_pkg.sv
btb/btb.sv
gshare/gshare_pht.sv
hw/bpred_combine.sv
hw/bpred_top.sv
bench/bpred_tb.sv

// File: btb/btb.sv
// direct-mapped, full-pc tags; a lookup in the same cycle as an update sees the old entry.
`default_nettype none
`timescale 1ns/1ps

module btb
    import bpred_pkg::*;
#(
    parameter int BTB_ENTRIES = 32
) (
    input  wire             clk,
    input  wire             arst_n_i,

    input  wire             req_valid_i,
    input  wire pred_req_t  req_i,

    input  wire             upd_valid_i,
    input  wire upd_req_t   upd_i,

    output logic            rsp_valid_o,
    output btb_rsp_t        rsp_o
);

    localparam int IDX_BITS = $clog2(BTB_ENTRIES);

    // ------------------------------
    // storage
    // ------------------------------
    logic [BTB_ENTRIES-1:0] valid_q;
    logic [XLEN-1:0]        tag_q    [BTB_ENTRIES];
    logic [XLEN-1:0]        target_q [BTB_ENTRIES];
    br_kind_e               kind_q   [BTB_ENTRIES];

    logic [IDX_BITS-1:0] rd_idx;
    logic [IDX_BITS-1:0] wr_idx;
    logic                rd_hit;
    logic                wr_en;

    assign rd_idx = req_i.pc[IDX_BITS+1:2];
    assign wr_idx = upd_i.pc[IDX_BITS+1:2];

    assign rd_hit = valid_q[rd_idx] && (tag_q[rd_idx] == req_i.pc);

    // taken or not, any real branch gets installed.
    assign wr_en = upd_valid_i && (upd_i.kind != BR_NONE);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= upd_i.pc;
            target_q[wr_idx] <= upd_i.target;
            kind_q[wr_idx]   <= upd_i.kind;
        end
    end

    // ------------------------------
    // registered lookup
    // ------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            rsp_o.hit    <= rd_hit;
            rsp_o.kind   <= rd_hit ? kind_q[rd_idx] : BR_NONE; // misses read as no branch.
            rsp_o.target <= target_q[rd_idx];
            rsp_o.pc     <= req_i.pc;
        end
    end

    // response follows its request by one cycle and carries that request's pc.
    a_rsp_timing: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        req_valid_i |=> (rsp_valid_o && (rsp_o.pc == $past(req_i.pc)))
    );

    a_no_spurious_rsp: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !req_valid_i |=> !rsp_valid_o
    );

endmodule

`default_nettype wire

// File: common/bpred_pkg.sv
// assumes word-aligned 32-bit pcs; branch kind comes from the resolving stage, not from decode.
`default_nettype none

package bpred_pkg;

    localparam int XLEN = 32;

    // ------------------------------
    // branch kinds
    // ------------------------------
    typedef enum logic [1:0] {
        BR_NONE = 2'd0, // not a control-flow instr.
        BR_COND = 2'd1,
        BR_JUMP = 2'd2  // jal / jalr, always taken.
    } br_kind_e;

    // counter value after reset, weakly not taken.
    localparam logic [1:0] CTR_INIT = 2'b01;

    // ------------------------------
    // request / response structs
    // ------------------------------
    typedef struct packed {
        logic [XLEN-1:0] pc; // bits 1:0 ignored.
    } pred_req_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target;
        br_kind_e        kind;
        logic            taken; // resolved outcome.
    } upd_req_t;

    typedef struct packed {
        logic            hit;
        br_kind_e        kind;
        logic [XLEN-1:0] target;
        logic [XLEN-1:0] pc; // looked-up pc, carried along.
    } btb_rsp_t;

    typedef struct packed {
        logic [1:0] counter;
        logic       taken;
    } dir_rsp_t;

    typedef struct packed {
        logic            taken;
        logic            hit;
        logic [XLEN-1:0] next_pc;
    } pred_rsp_t;

endpackage

`default_nettype wire

// File: gshare/gshare_pht.sv
// history shifts only on resolved conditional branches; GHR_BITS must be at least 2.
`default_nettype none
`timescale 1ns/1ps

module gshare_pht
    import bpred_pkg::*;
#(
    parameter int GHR_BITS = 5
) (
    input  wire             clk,
    input  wire             arst_n_i,

    input  wire             req_valid_i,
    input  wire pred_req_t  req_i,

    input  wire             upd_valid_i,
    input  wire upd_req_t   upd_i,

    input  wire             hist_clear_i, // pipeline flush.

    output dir_rsp_t        rsp_o
);

    localparam int PHT_ENTRIES = 1 << GHR_BITS;

    logic [GHR_BITS-1:0] ghr_q;
    logic [1:0]          pht_q [PHT_ENTRIES];

    logic [GHR_BITS-1:0] rd_idx;
    logic [GHR_BITS-1:0] wr_idx;
    logic [1:0]          rd_ctr;
    logic [1:0]          wr_ctr;
    logic [1:0]          wr_ctr_next;
    logic                cond_upd;

    assign cond_upd = upd_valid_i && (upd_i.kind == BR_COND);

    assign rd_idx = req_i.pc[GHR_BITS+1:2] ^ ghr_q;
    assign wr_idx = upd_i.pc[GHR_BITS+1:2] ^ ghr_q;

    assign rd_ctr = pht_q[rd_idx];
    assign wr_ctr = pht_q[wr_idx];

    // ------------------------------
    // saturating counter step
    // ------------------------------
    always_comb begin
        wr_ctr_next = wr_ctr;
        if (upd_i.taken) begin
            if (wr_ctr != 2'b11) wr_ctr_next = wr_ctr + 2'd1;
        end else begin
            if (wr_ctr != 2'b00) wr_ctr_next = wr_ctr - 2'd1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht_q[i] <= CTR_INIT;
            end
        end else if (cond_upd) begin
            pht_q[wr_idx] <= wr_ctr_next; // indexed with pre-shift ghr.
        end
    end

    // clear wins over a shift in the same cycle.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ghr_q <= '0;
        end else if (hist_clear_i) begin
            ghr_q <= '0;
        end else if (cond_upd) begin
            ghr_q <= {ghr_q[GHR_BITS-2:0], upd_i.taken};
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            rsp_o.counter <= rd_ctr;
            rsp_o.taken   <= rd_ctr[1];
        end
    end

    // each counter moves at most one step per edge.
    for (genvar i = 0; i < PHT_ENTRIES; i++) begin : g_ctr_chk
        a_ctr_step: assert property (
            @(posedge clk) disable iff (!arst_n_i)
            ((pht_q[i] > $past(pht_q[i])) ? (pht_q[i] - $past(pht_q[i]))
                                          : ($past(pht_q[i]) - pht_q[i])) <= 2'd1
        );
    end

endmodule

`default_nettype wire

// File: hw/bpred_combine.sv
// purely combinational; inputs are the registered target-buffer and counter results.
`default_nettype none
`timescale 1ns/1ps

module bpred_combine
    import bpred_pkg::*;
(
    input  wire             btb_valid_i,
    input  wire btb_rsp_t   btb_i,
    input  wire dir_rsp_t   dir_i,

    output logic            pred_valid_o,
    output pred_rsp_t       pred_o
);

    logic is_jump;
    logic is_cond_taken;
    logic is_taken;

    // ------------------------------
    // direction
    // ------------------------------
    assign is_jump       = (btb_i.kind == BR_JUMP);
    assign is_cond_taken = (btb_i.kind == BR_COND) && dir_i.taken;

    assign is_taken = btb_i.hit && (is_jump || is_cond_taken);

    // ------------------------------
    // next fetch address
    // ------------------------------
    assign pred_valid_o   = btb_valid_i;
    assign pred_o.taken   = is_taken;
    assign pred_o.hit     = btb_i.hit;
    assign pred_o.next_pc = is_taken ? btb_i.target
                                     : btb_i.pc + XLEN'(4); // fall through.

    // a jump that hits must redirect fetch.
    always_comb begin
        if (pred_valid_o && btb_i.hit && is_jump) begin
            a_jump_taken: assert (pred_o.taken)
                else $error("jump hit in target buffer but predicted not taken.");
        end
    end

endmodule

`default_nettype wire

// File: hw/bpred_top.sv
// one-cycle prediction latency, no back-pressure; updates are not bypassed to same-cycle lookups.
`default_nettype none
`timescale 1ns/1ps

module bpred_top
    import bpred_pkg::*;
#(
    parameter int BTB_ENTRIES = 32, // power of two.
    parameter int GHR_BITS    = 5
) (
    input  wire             clk,
    input  wire             arst_n_i,

    input  wire             pred_req_valid_i,
    input  wire pred_req_t  pred_req_i,

    input  wire             upd_valid_i,
    input  wire upd_req_t   upd_i,

    input  wire             hist_clear_i,

    output logic            pred_valid_o,
    output pred_rsp_t       pred_o
);

    logic     btb_valid;
    btb_rsp_t btb_rsp;
    dir_rsp_t dir_rsp;

    // ------------------------------
    // target buffer
    // ------------------------------
    btb #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) i_btb (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_valid_i (pred_req_valid_i),
        .req_i       (pred_req_i),
        .upd_valid_i (upd_valid_i),
        .upd_i       (upd_i),
        .rsp_valid_o (btb_valid),
        .rsp_o       (btb_rsp)
    );

    // ------------------------------
    // direction predictor
    // ------------------------------
    gshare_pht #(
        .GHR_BITS (GHR_BITS)
    ) i_gshare_pht (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (pred_req_valid_i),
        .req_i        (pred_req_i),
        .upd_valid_i  (upd_valid_i),
        .upd_i        (upd_i),
        .hist_clear_i (hist_clear_i),
        .rsp_o        (dir_rsp)
    );

    // both results are registered, so they line up here.
    bpred_combine i_bpred_combine (
        .btb_valid_i  (btb_valid),
        .btb_i        (btb_rsp),
        .dir_i        (dir_rsp),
        .pred_valid_o (pred_valid_o),
        .pred_o       (pred_o)
    );

endmodule

`default_nettype wire
